/* Makefile */
TOP = heat_display_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --top-module $(TOP) -f heat_display_top.f --Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) | tee run.log
	grep -q "^TESTS PASSED$$" run.log

clean:
	rm -rf $(OBJ) run.log

/* heat_display_top.f */
hw/dot_matrix_pkg.sv
hw/scan_tick_gen.sv
hw/frame_sequencer.sv
hw/dot_matrix_scanner.sv
hw/heat_display_top.sv
tb/heat_display_tb.sv

/* hw/dot_matrix_pkg.sv */
package dot_matrix_pkg;

    // glyph index on the 8x8 matrix
    typedef enum logic [3:0] {
        fill_0  = 4'd0,  // empty vessel
        fill_1  = 4'd1,
        fill_2  = 4'd2,
        fill_3  = 4'd3,
        fill_4  = 4'd4,
        fill_5  = 4'd5,  // full vessel
        flame_a = 4'd6,
        flame_b = 4'd7,
        face    = 4'd8,  // red only
        cup     = 4'd9,
        drop    = 4'd10,
        warn    = 4'd11  // over-temperature, red only
    } frame_t;

    // sequencer states
    typedef enum logic [1:0] {
        idle    = 2'd0,
        filling = 2'd1,
        heating = 2'd2,
        done    = 2'd3
    } seq_state_t;

    // 50 MHz system clock down to a 1 kHz row rate
    localparam int SCAN_DIV_DEFAULT = 50000;

    // 1 kHz ticks per animation step, about a quarter second
    localparam int FRAME_TICKS_DEFAULT = 250;

endpackage

/* hw/dot_matrix_scanner.sv */
`timescale 1ns/1ns

module dot_matrix_scanner (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   st,
    input  logic                   scan_tick,
    input  logic                   temp,
    input  dot_matrix_pkg::frame_t frame,
    output logic [7:0]             row,
    output logic [7:0]             colr,
    output logic [7:0]             colg
);

    logic [2:0] row_idx;
    logic [7:0] green_pix;
    logic [7:0] red_pix;

    // green glyph table
    function automatic logic [7:0] green_row(input dot_matrix_pkg::frame_t f,
                                             input logic [2:0] r);
        logic [7:0] pix;
        pix = 8'h00;
        case (f)
            dot_matrix_pkg::fill_0:
                case (r)
                    3'd2, 3'd5: pix = 8'b0001_1000;
                    3'd3, 3'd4: pix = 8'b0011_1100;
                    default:    pix = 8'h00;
                endcase
            dot_matrix_pkg::fill_1:
                case (r)
                    3'd2, 3'd5: pix = 8'b0011_1000;
                    3'd3, 3'd4: pix = 8'b0111_1100;
                    default:    pix = 8'h00;
                endcase
            dot_matrix_pkg::fill_2:
                case (r)
                    3'd2, 3'd5: pix = 8'b0011_1100;
                    3'd3, 3'd4: pix = 8'b0111_1110;
                    default:    pix = 8'h00;
                endcase
            dot_matrix_pkg::fill_3:
                case (r)
                    3'd1, 3'd6:             pix = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: pix = 8'b0111_1110;
                    default:                pix = 8'h00;
                endcase
            dot_matrix_pkg::fill_4:
                case (r)
                    3'd0, 3'd7: pix = 8'b0011_1100;
                    3'd1, 3'd6: pix = 8'b0111_1110;
                    default:    pix = 8'b1111_1111;
                endcase
            dot_matrix_pkg::fill_5:
                pix = 8'b1111_1111; // brim full
            dot_matrix_pkg::flame_a:
                case (r)
                    3'd0:    pix = 8'b1100_0011;
                    3'd1:    pix = 8'b1110_0011;
                    3'd2:    pix = 8'b1111_0001;
                    3'd3:    pix = 8'b1110_0011;
                    3'd4:    pix = 8'b1100_0111;
                    3'd5:    pix = 8'b1110_0111;
                    3'd6:    pix = 8'b1111_0111;
                    default: pix = 8'b1111_1011;
                endcase
            dot_matrix_pkg::flame_b:
                case (r)
                    3'd1:    pix = 8'b0000_0001;
                    3'd2:    pix = 8'b1000_0001;
                    3'd3:    pix = 8'b1100_0011;
                    3'd4:    pix = 8'b1000_0011;
                    3'd5:    pix = 8'b1100_0111;
                    3'd6:    pix = 8'b1110_0111;
                    3'd7:    pix = 8'b1111_0011;
                    default: pix = 8'h00;
                endcase
            dot_matrix_pkg::cup:
                case (r)
                    3'd2:    pix = 8'b0110_0000;
                    3'd3:    pix = 8'b1111_1100;
                    3'd4:    pix = 8'b0011_1111;
                    3'd5:    pix = 8'b0011_1110;
                    3'd6:    pix = 8'b0001_1100;
                    default: pix = 8'h00;
                endcase
            dot_matrix_pkg::drop:
                case (r)
                    3'd2:       pix = 8'b0001_1000;
                    3'd3:       pix = 8'b0011_1100;
                    3'd4, 3'd5: pix = 8'b0111_1110;
                    3'd6:       pix = 8'b0010_0100;
                    default:    pix = 8'h00;
                endcase
            default:
                pix = 8'h00; // face and warn have no green
        endcase
        return pix;
    endfunction

    // smiley, red only
    function automatic logic [7:0] face_row(input logic [2:0] r);
        logic [7:0] pix;
        case (r)
            3'd1:    pix = 8'b0011_1000;
            3'd2:    pix = 8'b0100_0100;
            3'd3:    pix = 8'b0101_1010;
            3'd4:    pix = 8'b0100_1010;
            3'd5:    pix = 8'b0011_0010;
            3'd6:    pix = 8'b1100_0100;
            3'd7:    pix = 8'b0011_1000;
            default: pix = 8'h00;
        endcase
        return pix;
    endfunction

    function automatic logic [7:0] warn_row(input logic [2:0] r);
        logic [7:0] pix;
        case (r)
            3'd0:    pix = 8'b1110_0000;
            3'd1:    pix = 8'b0110_0000;
            3'd2:    pix = 8'b1110_0000;
            3'd3:    pix = 8'b0011_0000;
            3'd4:    pix = 8'b0011_0001;
            3'd5:    pix = 8'b0011_0011;
            3'd6:    pix = 8'b0011_1110;
            default: pix = 8'b0001_1100;
        endcase
        return pix;
    endfunction

    assign green_pix = green_row(frame, row_idx);

    // red plane: own glyphs, or a copy of green for amber
    always_comb
    begin
        case (frame)
            dot_matrix_pkg::face:
                red_pix = face_row(row_idx);
            dot_matrix_pkg::warn:
                red_pix = warn_row(row_idx);
            dot_matrix_pkg::flame_a, dot_matrix_pkg::flame_b, dot_matrix_pkg::cup:
                red_pix = green_pix;
            dot_matrix_pkg::drop:
                red_pix = 8'h00;
            default:
                red_pix = temp ? green_pix : 8'h00; // fill frames go amber when hot
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= 3'd0;
        else if (!st)
            row_idx <= 3'd0;
        else if (scan_tick)
            row_idx <= row_idx + 3'd1; // wraps after row 7
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= 8'hff;
            colr <= 8'h00;
            colg <= 8'h00;
        end
        else if (!st)
        begin
            row  <= 8'hff; // blank
            colr <= 8'h00;
            colg <= 8'h00;
        end
        else
        begin
            row  <= ~(8'h01 << row_idx); // active low select
            colr <= red_pix;
            colg <= green_pix;
        end
    end

endmodule

/* hw/frame_sequencer.sv */
`timescale 1ns/1ns

module frame_sequencer #(
    parameter int FRAME_TICKS = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   st,
    input  logic                   temp,
    input  logic                   ready,
    input  logic                   scan_tick,
    output dot_matrix_pkg::frame_t frame
);

    localparam int CNT_W = $clog2(FRAME_TICKS);

    dot_matrix_pkg::seq_state_t state;
    dot_matrix_pkg::frame_t     flame_alt;
    logic [CNT_W-1:0]           tick_cnt;
    logic                       frame_end;

    assign frame_end = (tick_cnt == CNT_W'(FRAME_TICKS - 1));

    // second flicker phase, red warning when overheated
    assign flame_alt = temp ? dot_matrix_pkg::warn : dot_matrix_pkg::flame_b;

    // scan ticks within the current animation step
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            tick_cnt <= '0;
        else if (!st)
            tick_cnt <= '0;
        else if (scan_tick)
        begin
            if (frame_end)
                tick_cnt <= '0;
            else
                tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= dot_matrix_pkg::idle;
            frame <= dot_matrix_pkg::fill_0;
        end
        else if (!st)
        begin
            state <= dot_matrix_pkg::idle;
            frame <= dot_matrix_pkg::fill_0;
        end
        else if (scan_tick)
        begin
            case (state)
                dot_matrix_pkg::idle:
                    state <= dot_matrix_pkg::filling; // first tick counts toward fill_0
                dot_matrix_pkg::filling:
                begin
                    if (ready)
                        state <= dot_matrix_pkg::done;
                    else if (frame_end)
                    begin
                        if (frame == dot_matrix_pkg::fill_5)
                        begin
                            state <= dot_matrix_pkg::heating;
                            frame <= dot_matrix_pkg::flame_a;
                        end
                        else
                            frame <= dot_matrix_pkg::frame_t'(frame + 4'd1);
                    end
                end
                dot_matrix_pkg::heating:
                begin
                    if (ready)
                        state <= dot_matrix_pkg::done;
                    else if (frame_end)
                    begin
                        if (frame == dot_matrix_pkg::flame_a)
                            frame <= flame_alt;
                        else
                            frame <= dot_matrix_pkg::flame_a;
                    end
                    else if (frame != dot_matrix_pkg::flame_a)
                        frame <= flame_alt; // follow temp within the b phase
                end
                dot_matrix_pkg::done:
                begin
                    // cup shows from the next step boundary on
                    if (frame_end)
                    begin
                        if (frame == dot_matrix_pkg::cup)
                            frame <= dot_matrix_pkg::face;
                        else
                            frame <= dot_matrix_pkg::cup;
                    end
                end
                default:
                    state <= dot_matrix_pkg::idle;
            endcase
        end
    end

endmodule

/* hw/heat_display_top.sv */
`timescale 1ns/1ns

module heat_display_top #(
    parameter int SCAN_DIV    = dot_matrix_pkg::SCAN_DIV_DEFAULT,
    parameter int FRAME_TICKS = dot_matrix_pkg::FRAME_TICKS_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       st,
    input  logic       temp,
    input  logic       ready,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    logic                   scan_tick;
    dot_matrix_pkg::frame_t frame;

    // row rate enable
    scan_tick_gen #(
        .SCAN_DIV (SCAN_DIV)
    ) u_tick (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .scan_tick (scan_tick)
    );

    frame_sequencer #(
        .FRAME_TICKS (FRAME_TICKS)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .temp      (temp),
        .ready     (ready),
        .scan_tick (scan_tick),
        .frame     (frame)
    );

    dot_matrix_scanner u_scan (
        .clk       (clk),
        .rst       (rst),
        .st        (st),
        .scan_tick (scan_tick),
        .temp      (temp),
        .frame     (frame),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

/* hw/scan_tick_gen.sv */
`timescale 1ns/1ns

module scan_tick_gen #(
    parameter int SCAN_DIV = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic st,
    output logic scan_tick
);

    localparam int CNT_W = $clog2(SCAN_DIV);

    logic [CNT_W-1:0] cnt;

    // down-counter, reloads from 0 so the first pulse lands SCAN_DIV clocks after st
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt       <= '0;
            scan_tick <= 1'b0;
        end
        else if (!st)
        begin
            cnt       <= '0;
            scan_tick <= 1'b0;
        end
        else
        begin
            if (cnt == '0)
                cnt <= CNT_W'(SCAN_DIV - 1);
            else
                cnt <= cnt - 1'b1;
            scan_tick <= (cnt == CNT_W'(1)); // one clock wide
        end
    end

endmodule

/* tb/heat_display_tb.sv */
`timescale 1ns/1ns

module heat_display_tb;

    localparam int SCAN_DIV    = 4;
    localparam int FRAME_TICKS = 8;
    localparam int CLK_PERIOD  = 100;
    localparam int DARK_CLOCKS = 30;
    localparam int NUM_FRAMES  = 12; // 11 in the cold run, 1 in the hot run
    localparam int TEST_CLOCKS = NUM_FRAMES * FRAME_TICKS * SCAN_DIV + 3 * DARK_CLOCKS + 20;
    localparam int WATCHDOG_NS = 2 * TEST_CLOCKS * CLK_PERIOD; // twice the expected length

    logic       clk;
    logic       rst;
    logic       st;
    logic       temp;
    logic       ready;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    int errors;
    int checks;
    int since_st; // falling edges since st went high

    heat_display_top #(
        .SCAN_DIV    (SCAN_DIV),
        .FRAME_TICKS (FRAME_TICKS)
    ) u_dut (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .temp  (temp),
        .ready (ready),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // row 0 sits in the top byte
    function automatic logic [63:0] green_glyph(input dot_matrix_pkg::frame_t f);
        case (f)
            dot_matrix_pkg::fill_0:  return 64'h0000_183c_3c18_0000;
            dot_matrix_pkg::fill_5:  return 64'hffff_ffff_ffff_ffff;
            dot_matrix_pkg::flame_a: return 64'hc3e3_f1e3_c7e7_f7fb;
            dot_matrix_pkg::cup:     return 64'h0000_60fc_3f3e_1c00;
            default:                 return 64'h0;
        endcase
    endfunction

    function automatic logic [63:0] red_glyph(input dot_matrix_pkg::frame_t f);
        case (f)
            dot_matrix_pkg::face: return 64'h0038_445a_4a32_c438;
            dot_matrix_pkg::warn: return 64'he060_e030_3133_3e1c;
            default:              return 64'h0;
        endcase
    endfunction

    function automatic logic [7:0] glyph_row(input logic [63:0] g, input int r);
        return 8'(g >> (8 * (7 - r)));
    endfunction

    function automatic logic [7:0] expected_green(input dot_matrix_pkg::frame_t f, input int r);
        return glyph_row(green_glyph(f), r);
    endfunction

    function automatic logic [7:0] expected_red(input dot_matrix_pkg::frame_t f, input int r,
                                                input logic hot);
        if (f == dot_matrix_pkg::face || f == dot_matrix_pkg::warn)
            return glyph_row(red_glyph(f), r);
        else if (hot && f != dot_matrix_pkg::drop)
            return expected_green(f, r); // amber
        else if (f == dot_matrix_pkg::flame_a || f == dot_matrix_pkg::flame_b ||
                 f == dot_matrix_pkg::cup)
            return expected_green(f, r);
        else
            return 8'h00;
    endfunction

    task automatic check_row(input logic [7:0] exp, input string what);
        checks++;
        if (row !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s, row %b expected %b", $time, what, row, exp);
        end
    endtask

    task automatic check_pair(input logic [7:0] exp_r, input logic [7:0] exp_g,
                              input string what);
        checks++;
        if (colr !== exp_r || colg !== exp_g)
        begin
            errors++;
            $display("error at %0t ns: %s, colr %b colg %b expected colr %b colg %b",
                     $time, what, colr, colg, exp_r, exp_g);
        end
    endtask

    task automatic check_cols(input dot_matrix_pkg::frame_t f, input int r, input logic hot);
        check_pair(expected_red(f, r, hot), expected_green(f, r),
                   $sformatf("%s row %0d temp %0d", f.name(), r, hot));
    endtask

    task automatic check_dark(input int clocks, input string what);
        repeat (clocks)
        begin
            @(negedge clk);
            check_row(8'hff, what);
            check_pair(8'h00, 8'h00, what);
        end
    endtask

    task automatic start_run(input logic hot);
        @(negedge clk);
        temp     = hot;
        ready    = 1'b0;
        st       = 1'b1;
        since_st = 0;
    endtask

    task automatic stop_run();
        st = 1'b0;
        check_dark(DARK_CLOCKS, "blank after st low");
    endtask

    task automatic wait_until(input int edges);
        while (since_st < edges)
        begin
            @(negedge clk);
            since_st++;
        end
    endtask

    // one clock after the tick that starts row period k
    task automatic check_period(input dot_matrix_pkg::frame_t f, input int k, input logic hot);
        int         r;
        logic [7:0] sel;
        r      = k % 8;
        sel    = 8'hff;
        sel[r] = 1'b0; // single low bit at the row index
        wait_until(SCAN_DIV * k + 2);
        check_row(sel, $sformatf("row period %0d", k));
        check_cols(f, r, hot);
    endtask

    task automatic sweep(input dot_matrix_pkg::frame_t f, input int frame_idx, input logic hot);
        int i;
        for (i = 0; i < 8; i++)
            check_period(f, frame_idx * FRAME_TICKS + i, hot);
    endtask

    task automatic test_reset_blank();
        check_dark(20, "blank after reset");
    endtask

    task automatic test_fill_cold();
        start_run(1'b0);
        sweep(dot_matrix_pkg::fill_0, 0, 1'b0);
        sweep(dot_matrix_pkg::fill_5, 5, 1'b0);
    endtask

    task automatic test_heat_and_done();
        int i;
        sweep(dot_matrix_pkg::flame_a, 6, 1'b0);
        temp = 1'b1;
        sweep(dot_matrix_pkg::warn, 7, 1'b1);
        check_period(dot_matrix_pkg::flame_a, 8 * FRAME_TICKS, 1'b1);
        ready = 1'b1; // early in the step so the next boundary brings cup
        for (i = 1; i < 8; i++)
            check_period(dot_matrix_pkg::flame_a, 8 * FRAME_TICKS + i, 1'b1);
        sweep(dot_matrix_pkg::cup, 9, 1'b1);
        sweep(dot_matrix_pkg::face, 10, 1'b1);
        stop_run();
    endtask

    task automatic test_fill_hot();
        start_run(1'b1);
        sweep(dot_matrix_pkg::fill_0, 0, 1'b1);
        stop_run();
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        st       = 1'b0;
        temp     = 1'b0;
        ready    = 1'b0;
        errors   = 0;
        checks   = 0;
        since_st = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_blank();
        test_fill_cold();
        test_heat_and_done();
        test_fill_hot();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
